// ==== verilog/eg_pkg.sv ====
// envelope generator types and constants, referenced by every block through eg_pkg::name
package eg_pkg;

	//////////////////////////////////////////////////////////////////////
	// level and bus constants
	localparam int LEVEL_W = 10;                            // attenuation bits
	localparam logic [LEVEL_W-1:0] LEVEL_MAX = 10'd1023;    // silent, 0 is loudest

	localparam int AXIL_ADDR_W = 12;  // byte address, 4 bytes per operator
	localparam int AXIL_DATA_W = 32;
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	//////////////////////////////////////////////////////////////////////
	// envelope phases
	typedef enum logic [1:0] {
		ATTACK  = 2'd0,
		DECAY1  = 2'd1,
		DECAY2  = 2'd2,
		RELEASE = 2'd3
	} eg_state_e;

	typedef logic [14:0] eg_cnt_t; // global envelope counter

	// one register word per operator, 24 bits
	typedef struct packed {
		logic [4:0] ar;    // attack rate
		logic [4:0] d1r;   // first decay rate
		logic [4:0] d2r;   // second decay (sustain) rate
		logic [3:0] rr;    // release rate, doubled+1 on use
		logic [3:0] d1l;   // sustain level, 15 = full scale
		logic       keyon;
	} op_cfg_t;

	// state that circulates per slot, 13 bits
	typedef struct packed {
		logic [LEVEL_W-1:0] level;
		eg_state_e          state;
		logic               keyon_last; // key seen on the previous visit
	} op_rec_t;

	// output stream word, 19 bits
	typedef struct packed {
		logic [7:0]         slot;
		logic [LEVEL_W-1:0] level;
		logic               valid;
	} eg_out_t;

	// idle record: released and silent
	localparam op_rec_t REC_IDLE = '{level: LEVEL_MAX, state: RELEASE, keyon_last: 1'b0};

endpackage

// ==== verilog/eg_cfg_regs.sv ====
// AXI4-Lite register file with one config word per operator, read back by slot for the pipeline
`timescale 1ns/1ns

module eg_cfg_regs #(
	parameter int NUM_OPS = 8,
	localparam int SLOT_W = $clog2(NUM_OPS)
) (
	input  logic                               clk,
	input  logic                               rst,
	// write address + data, taken together
	input  logic                               s_axil_awvalid,
	output logic                               s_axil_awready,
	input  logic [eg_pkg::AXIL_ADDR_W-1:0]     s_axil_awaddr,
	input  logic                               s_axil_wvalid,
	output logic                               s_axil_wready,
	input  logic [eg_pkg::AXIL_DATA_W-1:0]     s_axil_wdata,
	input  logic [eg_pkg::AXIL_DATA_W/8-1:0]   s_axil_wstrb,
	output logic                               s_axil_bvalid,
	input  logic                               s_axil_bready,
	output logic [1:0]                         s_axil_bresp,
	// read channels
	input  logic                               s_axil_arvalid,
	output logic                               s_axil_arready,
	input  logic [eg_pkg::AXIL_ADDR_W-1:0]     s_axil_araddr,
	output logic                               s_axil_rvalid,
	input  logic                               s_axil_rready,
	output logic [eg_pkg::AXIL_DATA_W-1:0]     s_axil_rdata,
	output logic [1:0]                         s_axil_rresp,
	// pipeline side
	input  logic [SLOT_W-1:0]                  slot,
	output eg_pkg::op_cfg_t                    cfg
);

	localparam int IDX_W = eg_pkg::AXIL_ADDR_W - 2; // word index bits

	eg_pkg::op_cfg_t  cfg_mem [NUM_OPS];
	logic             wr_fire, rd_fire;
	logic             wr_ok, rd_ok;  // index in range
	logic [IDX_W-1:0] wr_idx, rd_idx;
	logic [23:0]      wr_word;       // merged by byte strobes

	assign wr_idx = s_axil_awaddr[eg_pkg::AXIL_ADDR_W-1:2];
	assign rd_idx = s_axil_araddr[eg_pkg::AXIL_ADDR_W-1:2];
	assign wr_ok  = wr_idx < IDX_W'(NUM_OPS);
	assign rd_ok  = rd_idx < IDX_W'(NUM_OPS);

	// aw and w accepted in the same cycle, one response outstanding at most
	assign wr_fire        = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
	assign s_axil_awready = wr_fire;
	assign s_axil_wready  = wr_fire;
	assign rd_fire        = s_axil_arvalid & ~s_axil_rvalid;
	assign s_axil_arready = ~s_axil_rvalid;

	always_comb begin
		wr_word = cfg_mem[wr_idx[SLOT_W-1:0]];
		for (int b = 0; b < 3; b++) begin
			if (s_axil_wstrb[b])
				wr_word[8*b +: 8] = s_axil_wdata[8*b +: 8]; // top byte has no storage
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s_axil_bvalid <= 1'b0;
			s_axil_rvalid <= 1'b0;
			for (int i = 0; i < NUM_OPS; i++)
				cfg_mem[i] <= '0; // all keys off
		end else begin
			if (wr_fire) begin
				s_axil_bvalid <= 1'b1;
				s_axil_bresp  <= wr_ok ? eg_pkg::RESP_OKAY : eg_pkg::RESP_SLVERR;
				if (wr_ok)
					cfg_mem[wr_idx[SLOT_W-1:0]] <= wr_word;
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				s_axil_rvalid <= 1'b1;
				s_axil_rresp  <= rd_ok ? eg_pkg::RESP_OKAY : eg_pkg::RESP_SLVERR;
				s_axil_rdata  <= rd_ok ? eg_pkg::AXIL_DATA_W'(cfg_mem[rd_idx[SLOT_W-1:0]]) : '0;
			end else if (s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
		end
	end

	assign cfg = cfg_mem[slot]; // seen by the sequencer this cycle

	// a response only ever follows an accepted write
	a_b_after_write: assert property (@(posedge clk) disable iff (rst)
		$rose(s_axil_bvalid) |-> $past(wr_fire))
		else $error("eg_cfg_regs: bvalid without an accepted write");

endmodule

// ==== verilog/eg_sequencer.sv ====
// slot sequencer: walks the operators, divides the envelope clock, and picks each slot's phase
`timescale 1ns/1ns

module eg_sequencer #(
	parameter int NUM_OPS = 8,
	localparam int SLOT_W = $clog2(NUM_OPS)
) (
	input  logic               clk,
	input  logic               rst,
	input  eg_pkg::op_cfg_t    cfg,      // config of the current slot
	input  eg_pkg::op_rec_t    rec_in,   // record back from the ring
	output logic [SLOT_W-1:0]  slot,
	output eg_pkg::op_rec_t    st1_rec,
	output logic [4:0]         st1_rate,
	output eg_pkg::eg_cnt_t    eg_cnt
);

	logic            last_slot;
	logic [1:0]      pass_cnt;   // counts 0..2, one tick per three passes
	logic            keyon_now, keyoff_now;
	logic            d1l_hit;
	eg_pkg::op_rec_t nxt_rec;
	logic [4:0]      nxt_rate;

	//////////////////////////////////////////////////////////////////////
	// slot counter and envelope divider
	assign last_slot = slot == SLOT_W'(NUM_OPS - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot     <= '0;
			pass_cnt <= '0;
			eg_cnt   <= '0;
		end else begin
			slot <= last_slot ? '0 : slot + 1'b1;
			if (last_slot) begin
				if (pass_cnt == 2'd2) begin
					pass_cnt <= '0;
					eg_cnt   <= eg_cnt + 1'b1;
				end else begin
					pass_cnt <= pass_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// key edges and phase choice
	assign keyon_now  =  cfg.keyon & ~rec_in.keyon_last;
	assign keyoff_now = ~cfg.keyon &  rec_in.keyon_last;
	// d1l 15 waits for silence, otherwise compare top level bits
	assign d1l_hit = (cfg.d1l == 4'hf) ? (rec_in.level == eg_pkg::LEVEL_MAX)
	                                   : (rec_in.level[eg_pkg::LEVEL_W-1 -: 4] >= cfg.d1l);

	always_comb begin
		nxt_rec            = rec_in;
		nxt_rec.keyon_last = cfg.keyon;
		nxt_rate           = {cfg.rr, 1'b1};
		if (keyon_now) begin
			nxt_rec.state = eg_pkg::ATTACK; // restart, level kept
			nxt_rate      = cfg.ar;
		end else if (!keyoff_now) begin
			case (rec_in.state)
				eg_pkg::ATTACK: begin
					nxt_rec.state = (rec_in.level == '0) ? eg_pkg::DECAY1 : eg_pkg::ATTACK;
					nxt_rate      = (rec_in.level == '0) ? cfg.d1r : cfg.ar;
				end
				eg_pkg::DECAY1: begin
					nxt_rec.state = d1l_hit ? eg_pkg::DECAY2 : eg_pkg::DECAY1;
					nxt_rate      = d1l_hit ? cfg.d2r : cfg.d1r;
				end
				eg_pkg::DECAY2: nxt_rate = cfg.d2r;
				default:        nxt_rate = {cfg.rr, 1'b1}; // release
			endcase
		end else begin
			nxt_rec.state = eg_pkg::RELEASE; // key-off edge
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st1_rec  <= eg_pkg::REC_IDLE;
			st1_rate <= '0;
		end else begin
			st1_rec  <= nxt_rec;
			st1_rate <= nxt_rate;
		end
	end

endmodule

// ==== verilog/eg_rate_step.sv ====
// rate stage: effective rate, envelope counter tap and the step decision for one slot
`timescale 1ns/1ns

module eg_rate_step (
	input  logic            clk,
	input  logic            rst,
	input  eg_pkg::op_rec_t st1_rec,
	input  logic [4:0]      st1_rate,
	input  eg_pkg::eg_cnt_t eg_cnt,
	output eg_pkg::op_rec_t st2_rec,
	output logic [5:0]      st2_rate,
	output logic            st2_step
);

	logic [5:0]      eff;       // effective rate 0..63
	logic            attack;
	logic [3:0]      shift;     // counter bit group position
	eg_pkg::eg_cnt_t lo_mask;
	logic [2:0]      grp;       // pattern index from the counter
	logic            lo_zero;
	logic [7:0]      pattern;
	logic            step;

	always_comb begin
		eff = {st1_rate, 1'b0}; // twice the rate, 0 stays 0, tops out at 62

		// attack taps the counter one octave faster
		attack = st1_rec.state == eg_pkg::ATTACK;
		if (attack)
			shift = (eff[5:2] >= 4'd11) ? 4'd0 : 4'd11 - eff[5:2];
		else
			shift = (eff[5:2] >= 4'd12) ? 4'd0 : 4'd12 - eff[5:2];

		grp     = 3'(eg_cnt >> shift);
		lo_mask = ~({15{1'b1}} << shift);
		lo_zero = (eg_cnt & lo_mask) == '0; // only on group boundaries

		// 4..8 steps out of eight
		if (attack && eff[5:2] == 4'hf)
			pattern = 8'b11111111;          // fastest attack
		else if (!attack && eff[5:2] == 4'h0)
			pattern = 8'b11111110;          // slowest decay
		else begin
			case (eff[1:0])
				2'd0:    pattern = 8'b10101010;
				2'd1:    pattern = 8'b11101010;
				2'd2:    pattern = 8'b11101110;
				default: pattern = 8'b11111110;
			endcase
		end

		step = (eff != '0) && lo_zero && pattern[grp]; // zero rate holds
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st2_rec  <= eg_pkg::REC_IDLE;
			st2_rate <= '0;
			st2_step <= 1'b0;
		end else begin
			st2_rec  <= st1_rec;
			st2_rate <= eff;
			st2_step <= step;
		end
	end

endmodule

// ==== verilog/eg_level_update.sv ====
// level stage: applies the attack or decay step and drives the slot output stream
`timescale 1ns/1ns

module eg_level_update #(
	parameter int NUM_OPS = 8
) (
	input  logic            clk,
	input  logic            rst,
	input  eg_pkg::op_rec_t st2_rec,
	input  logic [5:0]      st2_rate,
	input  logic            st2_step,
	output eg_pkg::op_rec_t rec_out,
	output eg_pkg::eg_out_t eg_out
);

	logic [eg_pkg::LEVEL_W-1:0] lvl, ar_dec, nxt_lvl;
	logic [eg_pkg::LEVEL_W:0]   dec_sum;   // one spare bit for saturation
	logic [3:0]                 inc;
	logic [1:0]                 warm;      // pipeline fill after reset
	logic                       out_on;

	//////////////////////////////////////////////////////////////////////
	// step arithmetic
	always_comb begin
		lvl = st2_rec.level;
		case (st2_rate[5:2])  // attack step shrinks as the level falls
			4'd13:        ar_dec = (lvl >> 3) + 1'b1;
			4'd14, 4'd15: ar_dec = (lvl >> 2) + 1'b1;
			default:      ar_dec = (lvl >> 4) + 1'b1;
		endcase
		case (st2_rate[5:2])
			4'd13:   inc = 4'd2;
			4'd14:   inc = 4'd4;
			4'd15:   inc = 4'd8;
			default: inc = 4'd1;
		endcase
		dec_sum = {1'b0, lvl} + (eg_pkg::LEVEL_W + 1)'(inc);

		nxt_lvl = lvl; // no step, hold
		if (st2_step) begin
			if (st2_rec.state == eg_pkg::ATTACK) begin
				if (st2_rate >= 6'd62)
					nxt_lvl = '0;  // instant attack
				else
					nxt_lvl = (lvl > ar_dec) ? lvl - ar_dec : '0;
			end else begin
				nxt_lvl = (dec_sum > eg_pkg::LEVEL_MAX) ? eg_pkg::LEVEL_MAX
				                                        : dec_sum[eg_pkg::LEVEL_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// record back to the ring, plus the output word
	assign out_on = warm == 2'd2;

	always_ff @(posedge clk) begin
		if (rst) begin
			warm    <= '0;
			rec_out <= eg_pkg::REC_IDLE;
			eg_out  <= '{slot: 8'd0, level: eg_pkg::LEVEL_MAX, valid: 1'b0};
		end else begin
			if (!out_on)
				warm <= warm + 1'b1;
			rec_out <= '{level: nxt_lvl, state: st2_rec.state, keyon_last: st2_rec.keyon_last};
			eg_out.level <= nxt_lvl;
			eg_out.valid <= out_on;   // slot 0 lands 3 cycles after reset
			if (!eg_out.valid || eg_out.slot == 8'(NUM_OPS - 1))
				eg_out.slot <= 8'd0;
			else
				eg_out.slot <= eg_out.slot + 1'b1;
		end
	end

	// attack only lowers the level and stops at 0
	a_attack_down: assert property (@(posedge clk) disable iff (rst)
		st2_rec.state == eg_pkg::ATTACK |=> rec_out.level <= $past(st2_rec.level))
		else $error("eg_level_update: level rose in attack");

	// only attack may bring the level down
	a_no_drop: assert property (@(posedge clk) disable iff (rst)
		st2_rec.state != eg_pkg::ATTACK |=> rec_out.level >= $past(st2_rec.level))
		else $error("eg_level_update: level fell outside attack");

endmodule

// ==== verilog/eg_delay_ring.sv ====
// delay ring that hands each slot's record back to the sequencer on its next turn
`timescale 1ns/1ns

module eg_delay_ring #(
	parameter int NUM_OPS = 8,
	parameter type payload_t = logic [7:0],
	parameter payload_t RST_VAL = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t din,
	output payload_t dout
);

	localparam int DEPTH = NUM_OPS - 3; // three stages live in the pipeline

	payload_t ring [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				ring[i] <= RST_VAL;
		end else begin
			ring[0] <= din;
			for (int i = 1; i < DEPTH; i++)
				ring[i] <= ring[i-1];
		end
	end

	assign dout = ring[DEPTH-1];

	// loop is NUM_OPS long only with at least one ring stage
	a_min_ops: assert property (@(posedge clk) NUM_OPS >= 4)
		else $error("eg_delay_ring: NUM_OPS below 4");

endmodule

// ==== verilog/eg_top.sv ====
// envelope generator top: AXI4-Lite config, slot pipeline and feedback ring, level stream out
`timescale 1ns/1ns

module eg_top #(
	parameter int NUM_OPS = 8
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               s_axil_awvalid,
	output logic                               s_axil_awready,
	input  logic [eg_pkg::AXIL_ADDR_W-1:0]     s_axil_awaddr,
	input  logic                               s_axil_wvalid,
	output logic                               s_axil_wready,
	input  logic [eg_pkg::AXIL_DATA_W-1:0]     s_axil_wdata,
	input  logic [eg_pkg::AXIL_DATA_W/8-1:0]   s_axil_wstrb,
	output logic                               s_axil_bvalid,
	input  logic                               s_axil_bready,
	output logic [1:0]                         s_axil_bresp,
	input  logic                               s_axil_arvalid,
	output logic                               s_axil_arready,
	input  logic [eg_pkg::AXIL_ADDR_W-1:0]     s_axil_araddr,
	output logic                               s_axil_rvalid,
	input  logic                               s_axil_rready,
	output logic [eg_pkg::AXIL_DATA_W-1:0]     s_axil_rdata,
	output logic [1:0]                         s_axil_rresp,
	output eg_pkg::eg_out_t                    eg_out
);

	localparam int SLOT_W = $clog2(NUM_OPS);

	logic [SLOT_W-1:0] slot;
	eg_pkg::op_cfg_t   cfg;
	eg_pkg::op_rec_t   rec_ring;  // ring -> sequencer
	eg_pkg::op_rec_t   rec_loop;  // level stage -> ring
	eg_pkg::op_rec_t   st1_rec, st2_rec;
	logic [4:0]        st1_rate;
	logic [5:0]        st2_rate;
	logic              st2_step;
	eg_pkg::eg_cnt_t   eg_cnt;

	eg_cfg_regs #(.NUM_OPS(NUM_OPS)) u_regs (
		.clk, .rst,
		.s_axil_awvalid, .s_axil_awready, .s_axil_awaddr,
		.s_axil_wvalid, .s_axil_wready, .s_axil_wdata, .s_axil_wstrb,
		.s_axil_bvalid, .s_axil_bready, .s_axil_bresp,
		.s_axil_arvalid, .s_axil_arready, .s_axil_araddr,
		.s_axil_rvalid, .s_axil_rready, .s_axil_rdata, .s_axil_rresp,
		.slot, .cfg
	);

	eg_sequencer #(.NUM_OPS(NUM_OPS)) u_seq (
		.clk, .rst, .cfg, .rec_in(rec_ring), .slot, .st1_rec, .st1_rate, .eg_cnt
	);

	eg_rate_step u_rate (
		.clk, .rst, .st1_rec, .st1_rate, .eg_cnt, .st2_rec, .st2_rate, .st2_step
	);

	eg_level_update #(.NUM_OPS(NUM_OPS)) u_level (
		.clk, .rst, .st2_rec, .st2_rate, .st2_step, .rec_out(rec_loop), .eg_out
	);

	eg_delay_ring #(
		.NUM_OPS  (NUM_OPS),
		.payload_t(eg_pkg::op_rec_t),
		.RST_VAL  (eg_pkg::REC_IDLE)
	) u_ring (
		.clk, .rst, .din(rec_loop), .dout(rec_ring)
	);

endmodule

// ==== sim/tb_eg.sv ====
// testbench for eg_top: drives AXI4-Lite config, keys operators and checks the level stream
`timescale 1ns/1ns

module tb_eg;

	localparam int NUM_OPS    = 8;
	localparam int SLOT_W     = $clog2(NUM_OPS);
	localparam int HS_TIMEOUT = 32;   // cycles per handshake wait

	logic                             clk, rst;
	logic                             s_axil_awvalid, s_axil_awready;
	logic [eg_pkg::AXIL_ADDR_W-1:0]   s_axil_awaddr;
	logic                             s_axil_wvalid, s_axil_wready;
	logic [eg_pkg::AXIL_DATA_W-1:0]   s_axil_wdata;
	logic [eg_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb;
	logic                             s_axil_bvalid, s_axil_bready;
	logic [1:0]                       s_axil_bresp;
	logic                             s_axil_arvalid, s_axil_arready;
	logic [eg_pkg::AXIL_ADDR_W-1:0]   s_axil_araddr;
	logic                             s_axil_rvalid, s_axil_rready;
	logic [eg_pkg::AXIL_DATA_W-1:0]   s_axil_rdata;
	logic [1:0]                       s_axil_rresp;
	eg_pkg::eg_out_t                  eg_out;

	// reference state kept by the stimulus
	logic [23:0]                shadow [NUM_OPS];     // last word written per operator
	logic [1:0]                 exp_bresp, exp_rresp;
	logic [31:0]                exp_rdata;
	logic [NUM_OPS-1:0]         keyed_mask;           // operator ever keyed on
	logic [NUM_OPS-1:0]         mono_mask;            // level may only rise
	logic [NUM_OPS-1:0]         hold_mask;            // level must stay put
	logic [eg_pkg::LEVEL_W-1:0] prev_level [NUM_OPS]; // level at the previous visit
	logic [7:0]                 exp_slot;             // slot due on the next valid word
	logic [SLOT_W-1:0]          cur_slot;
	integer                     seed;

	eg_top #(.NUM_OPS(NUM_OPS)) dut (
		.clk, .rst,
		.s_axil_awvalid, .s_axil_awready, .s_axil_awaddr,
		.s_axil_wvalid, .s_axil_wready, .s_axil_wdata, .s_axil_wstrb,
		.s_axil_bvalid, .s_axil_bready, .s_axil_bresp,
		.s_axil_arvalid, .s_axil_arready, .s_axil_araddr,
		.s_axil_rvalid, .s_axil_rready, .s_axil_rdata, .s_axil_rresp,
		.eg_out
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	assign cur_slot = eg_out.slot[SLOT_W-1:0];

	// own slot count, restarts while the stream is idle
	always @(posedge clk) begin
		if (eg_out.valid) begin
			prev_level[cur_slot] <= eg_out.level;
			exp_slot <= (exp_slot == 8'(NUM_OPS - 1)) ? 8'd0 : exp_slot + 8'd1;
		end else begin
			exp_slot <= 8'd0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	// field order follows the register word, ar on top
	function automatic logic [31:0] pack_cfg(input logic [4:0] ar, input logic [4:0] d1r,
		input logic [4:0] d2r, input logic [3:0] rr, input logic [3:0] d1l, input logic keyon);
		return {8'h00, ar, d1r, d2r, rr, d1l, keyon};
	endfunction

	task automatic write_reg(input int idx, input logic [31:0] data);
		int n;
		n = 0;
		@(posedge clk);
		exp_bresp = (idx < NUM_OPS) ? eg_pkg::RESP_OKAY : eg_pkg::RESP_SLVERR;
		if (idx < NUM_OPS) begin
			shadow[idx] = data[23:0]; // top byte has no storage
			if (data[0])
				keyed_mask[idx] <= 1'b1;
		end
		s_axil_awaddr  <= eg_pkg::AXIL_ADDR_W'(4 * idx);
		s_axil_wdata   <= data;
		s_axil_wstrb   <= 4'hf;
		s_axil_awvalid <= 1'b1;
		s_axil_wvalid  <= 1'b1;
		@(negedge clk);
		while (!(s_axil_awready && s_axil_wready)) begin
			if (n == HS_TIMEOUT)
				stop_with_fail("timeout waiting for awready and wready");
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		s_axil_awvalid <= 1'b0;
		s_axil_wvalid  <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!s_axil_bvalid) begin
			if (n == HS_TIMEOUT)
				stop_with_fail("timeout waiting for the write response");
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		s_axil_bready <= 1'b1; // response has to wait a cycle for ready
		@(posedge clk);
		s_axil_bready <= 1'b0; // response taken on this edge
	endtask

	task automatic read_reg(input int idx);
		int n;
		n = 0;
		@(posedge clk);
		exp_rresp = (idx < NUM_OPS) ? eg_pkg::RESP_OKAY : eg_pkg::RESP_SLVERR;
		exp_rdata = (idx < NUM_OPS) ? {8'h00, shadow[idx]} : 32'h0;
		s_axil_araddr  <= eg_pkg::AXIL_ADDR_W'(4 * idx);
		s_axil_arvalid <= 1'b1;
		@(negedge clk);
		while (!s_axil_arready) begin
			if (n == HS_TIMEOUT)
				stop_with_fail("timeout waiting for arready");
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		s_axil_arvalid <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!s_axil_rvalid) begin
			if (n == HS_TIMEOUT)
				stop_with_fail("timeout waiting for read data");
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		s_axil_rready <= 1'b1; // data has to wait a cycle for ready
		@(posedge clk);
		s_axil_rready <= 1'b0;
	endtask

	// sampled on the falling edge, away from the register updates
	task automatic wait_level(input int op, input int lo, input int hi, input int max_cycles,
		input string what);
		int n;
		n = 0;
		forever begin
			@(negedge clk);
			if (eg_out.valid && eg_out.slot == 8'(op) && eg_out.level >= lo && eg_out.level <= hi)
				break;
			n++;
			if (n >= max_cycles)
				stop_with_fail($sformatf("timeout at %0t waiting for %s", $time, what));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	initial begin
		logic [31:0] word;
		int          n;
		seed           = 32'h34e6;
		rst            = 1'b1;
		s_axil_awvalid = 1'b0;
		s_axil_awaddr  = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wstrb   = '0;
		s_axil_bready  = 1'b0;
		s_axil_arvalid = 1'b0;
		s_axil_araddr  = '0;
		s_axil_rready  = 1'b0;
		exp_bresp      = eg_pkg::RESP_OKAY;
		exp_rresp      = eg_pkg::RESP_OKAY;
		exp_rdata      = '0;
		keyed_mask     = '0;
		mono_mask      = '0;
		hold_mask      = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		n = 0;
		while (!eg_out.valid) begin
			@(negedge clk);
			n++;
			if (n > 8)
				stop_with_fail("output stream never became valid after reset");
		end

		// random words with key off, each read back
		for (int i = 0; i < NUM_OPS; i++) begin
			word    = $random(seed);
			word[0] = 1'b0;
			write_reg(i, word);
			read_reg(i);
		end
		write_reg(NUM_OPS, 32'hffff_ffff); // out of range, same low index bits as op 0
		read_reg(NUM_OPS);
		read_reg(1023);
		read_reg(0);                       // op 0 untouched by the stray write

		// op 0: instant attack, slow decay, later released
		write_reg(0, pack_cfg(5'd31, 5'd24, 5'd10, 4'd15, 4'd8, 1'b1));
		wait_level(0, 0, 0, 2 * NUM_OPS, "op 0 attack to level 0");
		@(posedge clk);
		mono_mask[0] <= 1'b1;

		// op 1: fast decay1 up to d1l 2, then d2r 0 holds
		write_reg(1, pack_cfg(5'd31, 5'd31, 5'd0, 4'd15, 4'd2, 1'b1));
		wait_level(1, 0, 0, 2 * NUM_OPS, "op 1 attack to level 0");
		@(posedge clk);
		mono_mask[1] <= 1'b1;
		wait_level(1, 2 * 64, eg_pkg::LEVEL_MAX, 100 * NUM_OPS, "op 1 decay past d1l");
		@(posedge clk);
		hold_mask[1] <= 1'b1;

		repeat (40 * NUM_OPS) @(posedge clk); // decay and hold keep running

		write_reg(0, pack_cfg(5'd31, 5'd24, 5'd10, 4'd15, 4'd8, 1'b0)); // key off
		wait_level(0, eg_pkg::LEVEL_MAX, eg_pkg::LEVEL_MAX, 600 * NUM_OPS,
			"op 0 release to silence");
		repeat (4 * NUM_OPS) @(posedge clk);

		$display("Simulation finished: PASS");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	a_bresp: assert property (@(posedge clk) disable iff (rst)
		s_axil_bvalid && s_axil_bready |-> s_axil_bresp == exp_bresp)
		else stop_with_fail($sformatf("mismatch at %0t: s_axil_bresp got %0d expected %0d",
			$time, $sampled(s_axil_bresp), $sampled(exp_bresp)));

	a_rresp: assert property (@(posedge clk) disable iff (rst)
		s_axil_rvalid && s_axil_rready |-> s_axil_rresp == exp_rresp)
		else stop_with_fail($sformatf("mismatch at %0t: s_axil_rresp got %0d expected %0d",
			$time, $sampled(s_axil_rresp), $sampled(exp_rresp)));

	a_rdata: assert property (@(posedge clk) disable iff (rst)
		s_axil_rvalid && s_axil_rready && exp_rresp == eg_pkg::RESP_OKAY
		|-> s_axil_rdata == exp_rdata)
		else stop_with_fail($sformatf("mismatch at %0t: s_axil_rdata got %h expected %h",
			$time, $sampled(s_axil_rdata), $sampled(exp_rdata)));

	// responses wait for their ready
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
		else stop_with_fail("write response dropped before bready");

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
		else stop_with_fail("read data dropped before rready");

	a_valid_stays: assert property (@(posedge clk) disable iff (rst)
		eg_out.valid |=> eg_out.valid)
		else stop_with_fail("eg_out.valid fell after rising");

	a_first_slot: assert property (@(posedge clk) disable iff (rst)
		$rose(eg_out.valid) |-> eg_out.slot == 8'd0)
		else stop_with_fail($sformatf("mismatch at %0t: eg_out.slot got %0d expected 0",
			$time, $sampled(eg_out.slot)));

	// slot walks 0..NUM_OPS-1 and wraps
	a_slot_step: assert property (@(posedge clk) disable iff (rst)
		eg_out.valid |-> eg_out.slot == exp_slot)
		else stop_with_fail($sformatf("mismatch at %0t: eg_out.slot got %0d expected %0d",
			$time, $sampled(eg_out.slot), $sampled(exp_slot)));

	a_idle_level: assert property (@(posedge clk) disable iff (rst)
		eg_out.valid && !keyed_mask[cur_slot] |-> eg_out.level == eg_pkg::LEVEL_MAX)
		else stop_with_fail($sformatf("mismatch at %0t: eg_out.level got %0d expected %0d",
			$time, $sampled(eg_out.level), eg_pkg::LEVEL_MAX));

	a_no_fall: assert property (@(posedge clk) disable iff (rst)
		eg_out.valid && mono_mask[cur_slot] |-> eg_out.level >= prev_level[cur_slot])
		else stop_with_fail($sformatf("level of slot %0d fell at %0t, from %0d to %0d",
			$sampled(cur_slot), $time, $sampled(prev_level[cur_slot]),
			$sampled(eg_out.level)));

	a_hold: assert property (@(posedge clk) disable iff (rst)
		eg_out.valid && hold_mask[cur_slot] |-> eg_out.level == prev_level[cur_slot])
		else stop_with_fail($sformatf("mismatch at %0t: eg_out.level got %0d expected %0d",
			$time, $sampled(eg_out.level), $sampled(prev_level[cur_slot])));

endmodule

// ==== project.f ====
verilog/eg_pkg.sv
verilog/eg_cfg_regs.sv
verilog/eg_sequencer.sv
verilog/eg_rate_step.sv
verilog/eg_level_update.sv
verilog/eg_delay_ring.sv
verilog/eg_top.sv
sim/tb_eg.sv

// ==== Makefile ====
# Verilator build and run for the envelope generator testbench

VERILATOR ?= verilator
TOP       ?= tb_eg
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
